/* src/rvvi_pkg.sv */
// Shared constants for the RVFI to RVVI trace adapter.
// Trace widths, CSR vector indices, configuration map and reset defaults.
// Import with rvvi_pkg::* in the module header.

package rvvi_pkg;

   ////////////////////////////////////////
   // Trace widths
   ////////////////////////////////////////
   localparam int XLEN        = 32;
   localparam int N_CSR       = 16;
   localparam int HALT_HOLD_W = 4;

   // Bit positions in the CSR writeback vector
   localparam int CSR_MSTATUS       = 0;
   localparam int CSR_MISA          = 1;
   localparam int CSR_MIE           = 2;
   localparam int CSR_MTVEC         = 3;
   localparam int CSR_MCOUNTINHIBIT = 4;
   localparam int CSR_MSCRATCH      = 5;
   localparam int CSR_MEPC          = 6;
   localparam int CSR_MCAUSE        = 7;
   localparam int CSR_MTVAL         = 8;
   localparam int CSR_MIP           = 9;
   localparam int CSR_TSELECT       = 10;
   localparam int CSR_DCSR          = 11;
   localparam int CSR_DPC           = 12;
   localparam int CSR_MCYCLE        = 13;
   localparam int CSR_MINSTRET      = 14;
   localparam int CSR_MHARTID       = 15;

   // Architectural address per vector index, same order as above
   localparam logic [11:0] csr_addr_tab [N_CSR] = '{
      12'h300, 12'h301, 12'h304, 12'h305,
      12'h320, 12'h340, 12'h341, 12'h342,
      12'h343, 12'h344, 12'h7A0, 12'h7B0,
      12'h7B1, 12'hB00, 12'hB02, 12'hF14
   };

   ////////////////////////////////////////
   // Configuration map
   ////////////////////////////////////////
   localparam int CFG_ADDR_W = 2;

   localparam logic [CFG_ADDR_W-1:0] CFG_CSR_EN    = 2'd0;
   localparam logic [CFG_ADDR_W-1:0] CFG_HALT_HOLD = 2'd1;
   localparam logic [CFG_ADDR_W-1:0] CFG_IRQ_MASK  = 2'd2;

   // All CSRs compared out of reset
   localparam logic [N_CSR-1:0] CSR_EN_DEFAULT = '1;
   // MSI, MTI, MEI and the sixteen local lines
   localparam logic [31:0] IRQ_MASK_DEFAULT = 32'hFFFF_0888;

endpackage

/* src/rvvi_cfg_regs.sv */
// Steering registers for the trace adapter.
// Written by a single-cycle strobe, read back combinationally by address.
// Feeds the CSR enable mask, halt hold length and interrupt line mask.

`timescale 1ns/100ps

module rvvi_cfg_regs import rvvi_pkg::*; #(
   parameter int HALT_HOLD_DEFAULT = 5
) (
   input  logic                   rvvi_i,
   input  logic                   rst_n_i,
   input  logic                   cfg_we_i,
   input  logic [CFG_ADDR_W-1:0]  cfg_addr_i,
   input  logic [XLEN-1:0]        cfg_wdata_i,
   output logic [XLEN-1:0]        cfg_rdata_o,
   output logic [N_CSR-1:0]       csr_en_o,
   output logic [HALT_HOLD_W-1:0] halt_hold_o,
   output logic [31:0]            irq_mask_o
);

   logic [N_CSR-1:0]       csr_en_q;
   logic [HALT_HOLD_W-1:0] halt_hold_q;
   logic [31:0]            irq_mask_q;

   // Write decode, unused address 3 falls through
   always_ff @(posedge rvvi_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         csr_en_q    <= CSR_EN_DEFAULT;
         halt_hold_q <= HALT_HOLD_W'(HALT_HOLD_DEFAULT);
         irq_mask_q  <= IRQ_MASK_DEFAULT;
      end else if (cfg_we_i) begin
         case (cfg_addr_i)
            CFG_CSR_EN:    csr_en_q    <= cfg_wdata_i[N_CSR-1:0];
            CFG_HALT_HOLD: halt_hold_q <= cfg_wdata_i[HALT_HOLD_W-1:0];
            CFG_IRQ_MASK:  irq_mask_q  <= cfg_wdata_i[31:0];
            default: ;
         endcase
      end
   end

   // Read mux, zero-extended
   always_comb begin
      case (cfg_addr_i)
         CFG_CSR_EN:    cfg_rdata_o = XLEN'(csr_en_q);
         CFG_HALT_HOLD: cfg_rdata_o = XLEN'(halt_hold_q);
         CFG_IRQ_MASK:  cfg_rdata_o = XLEN'(irq_mask_q);
         default:       cfg_rdata_o = '0;
      endcase
   end

   assign csr_en_o    = csr_en_q;
   assign halt_hold_o = halt_hold_q;
   assign irq_mask_o  = irq_mask_q;

   // An unknown write address would corrupt the steering state silently
   a_cfg_addr_known: assert property (
      @(posedge rvvi_i) disable iff (!rst_n_i)
      cfg_we_i |-> !$isunknown(cfg_addr_i)
   );

endmodule

/* src/rvvi_retire_capture.sv */
// Retirement record capture for the RVVI side.
// Samples the RVFI record on each valid strobe and holds it until the next.
// The destination write becomes a one-hot GPR writeback mask plus one data word.

`timescale 1ns/100ps

module rvvi_retire_capture import rvvi_pkg::*; #(
   parameter int NRET_ORDER_W = 64
) (
   input  logic                    rvvi_i,
   input  logic                    rst_n_i,
   // RVFI retirement port
   input  logic                    rvfi_valid_i,
   input  logic [NRET_ORDER_W-1:0] rvfi_order_i,
   input  logic [XLEN-1:0]         rvfi_insn_i,
   input  logic                    rvfi_trap_i,
   input  logic                    rvfi_intr_i,
   input  logic [1:0]              rvfi_mode_i,
   input  logic [1:0]              rvfi_ixl_i,
   input  logic [XLEN-1:0]         rvfi_pc_rdata_i,
   input  logic [XLEN-1:0]         rvfi_pc_wdata_i,
   input  logic [4:0]              rvfi_rd_addr_i,
   input  logic [XLEN-1:0]         rvfi_rd_wdata_i,
   // RVVI record
   output logic                    rvvi_valid_o,
   output logic [NRET_ORDER_W-1:0] rvvi_order_o,
   output logic [XLEN-1:0]         rvvi_insn_o,
   output logic                    rvvi_trap_o,
   output logic                    rvvi_intr_o,
   output logic [1:0]              rvvi_mode_o,
   output logic [1:0]              rvvi_ixl_o,
   output logic [XLEN-1:0]         rvvi_pc_rdata_o,
   output logic [XLEN-1:0]         rvvi_pc_wdata_o,
   output logic [31:0]             x_wb_o,
   output logic [XLEN-1:0]         x_wdata_o
);

   logic            rd_is_x0;
   logic [31:0]     x_wb_d;
   logic [XLEN-1:0] x_wdata_d;
   logic            have_ret_q;

   // x0 is hardwired, so a write to it is not reported
   assign rd_is_x0  = (rvfi_rd_addr_i == 5'd0);
   assign x_wb_d    = rd_is_x0 ? 32'd0 : (32'd1 << rvfi_rd_addr_i);
   assign x_wdata_d = rd_is_x0 ? '0 : rvfi_rd_wdata_i;

   ////////////////////////////////////////
   // Control state
   ////////////////////////////////////////
   always_ff @(posedge rvvi_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rvvi_valid_o <= 1'b0;
         x_wb_o       <= '0;
         have_ret_q   <= 1'b0;
      end else begin
         // One-cycle pulse per retirement
         rvvi_valid_o <= rvfi_valid_i;
         if (rvfi_valid_i) begin
            x_wb_o     <= x_wb_d;
            have_ret_q <= 1'b1;
         end
      end
   end

   // Record payload, held between retirements
   always_ff @(posedge rvvi_i) begin
      if (rvfi_valid_i) begin
         rvvi_order_o    <= rvfi_order_i;
         rvvi_insn_o     <= rvfi_insn_i;
         rvvi_trap_o     <= rvfi_trap_i;
         rvvi_intr_o     <= rvfi_intr_i;
         rvvi_mode_o     <= rvfi_mode_i;
         rvvi_ixl_o      <= rvfi_ixl_i;
         rvvi_pc_rdata_o <= rvfi_pc_rdata_i;
         rvvi_pc_wdata_o <= rvfi_pc_wdata_i;
         x_wdata_o       <= x_wdata_d;
      end
   end

   // Held order is the last retired one, so each new retirement must exceed it
   a_order_incr: assert property (
      @(posedge rvvi_i) disable iff (!rst_n_i)
      (rvfi_valid_i && have_ret_q) |-> (rvfi_order_i > rvvi_order_o)
   );

endmodule

/* src/rvvi_csr_trace.sv */
// CSR writeback tracing for the RVVI side.
// Each traced CSR gets a writeback bit from its write mask, gated by the
// compare-enable mask, plus its data masked to the written bits.
// Both are sampled on the retirement strobe, aligned with the record capture.

`timescale 1ns/100ps

module rvvi_csr_trace import rvvi_pkg::*; (
   input  logic                        rvvi_i,
   input  logic                        rst_n_i,
   input  logic                        rvfi_valid_i,
   // Per-CSR RVFI write buses, indexed by the package CSR constants
   input  logic [N_CSR-1:0][XLEN-1:0]  csr_wmask_i,
   input  logic [N_CSR-1:0][XLEN-1:0]  csr_wdata_i,
   // Compare-enable from the config block
   input  logic [N_CSR-1:0]            csr_en_i,
   output logic [N_CSR-1:0]            csr_wb_o,
   output logic [N_CSR-1:0][XLEN-1:0]  csr_data_o
);

   logic [N_CSR-1:0]           csr_wb_d;
   logic [N_CSR-1:0][XLEN-1:0] csr_data_d;

   ////////////////////////////////////////
   // Per-CSR gather
   ////////////////////////////////////////
   always_comb begin
      for (int i = 0; i < N_CSR; i++) begin
         // Any written bit counts as a write
         csr_wb_d[i]   = (|csr_wmask_i[i]) & csr_en_i[i];
         // Only the bits the core actually wrote
         csr_data_d[i] = csr_wdata_i[i] & csr_wmask_i[i];
      end
   end

   // Writeback vector, replaced on every retirement
   // A retirement without CSR writes clears it
   always_ff @(posedge rvvi_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         csr_wb_o <= '0;
      end else if (rvfi_valid_i) begin
         csr_wb_o <= csr_wb_d;
      end
   end

   // Masked data, held with the record
   always_ff @(posedge rvvi_i) begin
      if (rvfi_valid_i) begin
         csr_data_o <= csr_data_d;
      end
   end

endmodule

/* src/rvvi_halt_stretch.sv */
// Debug halt request stretcher.
// Turns the core's debug request into the reference halt net, held for a
// configurable number of edges after the request drops.
// Also flags each change of the halt net with a one-cycle event.

`timescale 1ns/100ps

module rvvi_halt_stretch import rvvi_pkg::*; (
   input  logic                   rvvi_i,
   input  logic                   rst_n_i,
   input  logic                   debug_req_i,
   input  logic [HALT_HOLD_W-1:0] halt_hold_i,
   output logic                   halt_o,
   output logic                   halt_evt_o
);

   logic [HALT_HOLD_W-1:0] hold_cnt_q;
   logic                   halt_q;
   logic                   halt_prev_q;
   logic                   halt_evt_q;

   ////////////////////////////////////////
   // Hold counter and halt net
   ////////////////////////////////////////
   always_ff @(posedge rvvi_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hold_cnt_q <= '0;
         halt_q     <= 1'b0;
      end else begin
         // Reload while requested, drain afterwards
         if (debug_req_i) begin
            hold_cnt_q <= halt_hold_i;
         end else if (hold_cnt_q != '0) begin
            hold_cnt_q <= hold_cnt_q - 1'b1;
         end
         // High on request or while hold remains
         halt_q <= debug_req_i | (hold_cnt_q != '0);
      end
   end

   // Change detect on the halt net
   // Event lands the cycle after the net moves
   always_ff @(posedge rvvi_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         halt_prev_q <= 1'b0;
         halt_evt_q  <= 1'b0;
      end else begin
         halt_prev_q <= halt_q;
         halt_evt_q  <= halt_q ^ halt_prev_q;
      end
   end

   assign halt_o     = halt_q;
   assign halt_evt_o = halt_evt_q;

endmodule

/* src/rvvi_irq_tracker.sv */
// Interrupt net tracker for the reference side.
// Masks the core's interrupt lines, registers them as the reference nets
// and pulses an event whenever the masked value changes.

`timescale 1ns/100ps

module rvvi_irq_tracker (
   input  logic        rvvi_i,
   input  logic        rst_n_i,
   input  logic [31:0] irq_i,
   input  logic [31:0] irq_mask_i,
   output logic [31:0] irq_net_o,
   output logic        irq_evt_o
);

   logic [31:0] irq_masked;
   logic [31:0] irq_net_q;
   logic        irq_evt_q;

   ////////////////////////////////////////
   // Masking and change detect
   ////////////////////////////////////////

   // Lines outside the mask never reach the reference
   assign irq_masked = irq_i & irq_mask_i;

   // Same edge loads the new value and raises the event,
   // so the pulse lines up with the first cycle of the new net
   always_ff @(posedge rvvi_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         irq_net_q <= '0;
         irq_evt_q <= 1'b0;
      end else begin
         irq_net_q <= irq_masked;
         irq_evt_q <= (irq_masked != irq_net_q);
      end
   end

   assign irq_net_o = irq_net_q;
   assign irq_evt_o = irq_evt_q;

endmodule

/* src/rvvi_trace_top.sv */
// Top level of the RVFI to RVVI trace adapter.
// Connects the configuration registers to the retirement, CSR, halt and
// interrupt blocks. Single clock domain on the rvvi clock.

`timescale 1ns/100ps

module rvvi_trace_top import rvvi_pkg::*; #(
   parameter int HALT_HOLD_DEFAULT = 5,
   parameter int NRET_ORDER_W      = 64
) (
   input  logic                        rvvi_i,
   input  logic                        rst_n_i,
   // Configuration access
   input  logic                        cfg_we_i,
   input  logic [CFG_ADDR_W-1:0]       cfg_addr_i,
   input  logic [XLEN-1:0]             cfg_wdata_i,
   output logic [XLEN-1:0]             cfg_rdata_o,
   // RVFI retirement port
   input  logic                        rvfi_valid_i,
   input  logic [NRET_ORDER_W-1:0]     rvfi_order_i,
   input  logic [XLEN-1:0]             rvfi_insn_i,
   input  logic                        rvfi_trap_i,
   input  logic                        rvfi_intr_i,
   input  logic [1:0]                  rvfi_mode_i,
   input  logic [1:0]                  rvfi_ixl_i,
   input  logic [XLEN-1:0]             rvfi_pc_rdata_i,
   input  logic [XLEN-1:0]             rvfi_pc_wdata_i,
   input  logic [4:0]                  rvfi_rd_addr_i,
   input  logic [XLEN-1:0]             rvfi_rd_wdata_i,
   input  logic [N_CSR-1:0][XLEN-1:0]  csr_wmask_i,
   input  logic [N_CSR-1:0][XLEN-1:0]  csr_wdata_i,
   // Asynchronous core inputs
   input  logic                        debug_req_i,
   input  logic [31:0]                 irq_i,
   // RVVI record
   output logic                        rvvi_valid_o,
   output logic [NRET_ORDER_W-1:0]     rvvi_order_o,
   output logic [XLEN-1:0]             rvvi_insn_o,
   output logic                        rvvi_trap_o,
   output logic                        rvvi_intr_o,
   output logic [1:0]                  rvvi_mode_o,
   output logic [1:0]                  rvvi_ixl_o,
   output logic [XLEN-1:0]             rvvi_pc_rdata_o,
   output logic [XLEN-1:0]             rvvi_pc_wdata_o,
   output logic [31:0]                 x_wb_o,
   output logic [XLEN-1:0]             x_wdata_o,
   output logic [N_CSR-1:0]            csr_wb_o,
   output logic [N_CSR-1:0][XLEN-1:0]  csr_data_o,
   // Reference nets
   output logic                        halt_o,
   output logic                        halt_evt_o,
   output logic [31:0]                 irq_net_o,
   output logic                        irq_evt_o
);

   // Steering from the config block
   logic [N_CSR-1:0]       csr_en;
   logic [HALT_HOLD_W-1:0] halt_hold;
   logic [31:0]            irq_mask;

   ////////////////////////////////////////
   // Configuration
   ////////////////////////////////////////
   rvvi_cfg_regs #(
      .HALT_HOLD_DEFAULT (HALT_HOLD_DEFAULT)
   ) u_cfg_regs (
      .rvvi_i      (rvvi_i),
      .rst_n_i     (rst_n_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_rdata_o (cfg_rdata_o),
      .csr_en_o    (csr_en),
      .halt_hold_o (halt_hold),
      .irq_mask_o  (irq_mask)
   );

   ////////////////////////////////////////
   // Retirement and CSR trace
   ////////////////////////////////////////
   rvvi_retire_capture #(
      .NRET_ORDER_W (NRET_ORDER_W)
   ) u_retire_capture (
      .rvvi_i          (rvvi_i),
      .rst_n_i         (rst_n_i),
      .rvfi_valid_i    (rvfi_valid_i),
      .rvfi_order_i    (rvfi_order_i),
      .rvfi_insn_i     (rvfi_insn_i),
      .rvfi_trap_i     (rvfi_trap_i),
      .rvfi_intr_i     (rvfi_intr_i),
      .rvfi_mode_i     (rvfi_mode_i),
      .rvfi_ixl_i      (rvfi_ixl_i),
      .rvfi_pc_rdata_i (rvfi_pc_rdata_i),
      .rvfi_pc_wdata_i (rvfi_pc_wdata_i),
      .rvfi_rd_addr_i  (rvfi_rd_addr_i),
      .rvfi_rd_wdata_i (rvfi_rd_wdata_i),
      .rvvi_valid_o    (rvvi_valid_o),
      .rvvi_order_o    (rvvi_order_o),
      .rvvi_insn_o     (rvvi_insn_o),
      .rvvi_trap_o     (rvvi_trap_o),
      .rvvi_intr_o     (rvvi_intr_o),
      .rvvi_mode_o     (rvvi_mode_o),
      .rvvi_ixl_o      (rvvi_ixl_o),
      .rvvi_pc_rdata_o (rvvi_pc_rdata_o),
      .rvvi_pc_wdata_o (rvvi_pc_wdata_o),
      .x_wb_o          (x_wb_o),
      .x_wdata_o       (x_wdata_o)
   );

   rvvi_csr_trace u_csr_trace (
      .rvvi_i       (rvvi_i),
      .rst_n_i      (rst_n_i),
      .rvfi_valid_i (rvfi_valid_i),
      .csr_wmask_i  (csr_wmask_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_en_i     (csr_en),
      .csr_wb_o     (csr_wb_o),
      .csr_data_o   (csr_data_o)
   );

   // Debug and interrupt nets
   rvvi_halt_stretch u_halt_stretch (
      .rvvi_i      (rvvi_i),
      .rst_n_i     (rst_n_i),
      .debug_req_i (debug_req_i),
      .halt_hold_i (halt_hold),
      .halt_o      (halt_o),
      .halt_evt_o  (halt_evt_o)
   );

   rvvi_irq_tracker u_irq_tracker (
      .rvvi_i     (rvvi_i),
      .rst_n_i    (rst_n_i),
      .irq_i      (irq_i),
      .irq_mask_i (irq_mask),
      .irq_net_o  (irq_net_o),
      .irq_evt_o  (irq_evt_o)
   );

endmodule

/* verification/rvvi_trace_tb.sv */
// Testbench for the RVFI to RVVI trace adapter.
// Builds a table of per-cycle stimulus with expected outputs from the adapter's
// rules, then applies it one row per clock and checks every row.
// Covers reset state, retirement, CSR writeback, halt stretch and interrupt nets.

`timescale 1ns/100ps

module rvvi_trace_tb
   import rvvi_pkg::*;
();

   localparam int HALT_HOLD_DEFAULT = 5;
   localparam int NRET_ORDER_W      = 64;

   // One table row is one clock of stimulus plus what the outputs show after it
   typedef struct packed {
      logic [2:0]                 test;
      logic                       we;
      logic [CFG_ADDR_W-1:0]      addr;
      logic [31:0]                wdata;
      logic                       valid;
      logic [63:0]                order;
      logic [31:0]                insn;
      logic                       trap;
      logic                       intr;
      logic [1:0]                 mode;
      logic [1:0]                 ixl;
      logic [31:0]                pc_r;
      logic [31:0]                pc_w;
      logic [4:0]                 rd;
      logic [31:0]                rd_wdata;
      logic [N_CSR-1:0][XLEN-1:0] wmask;
      logic [N_CSR-1:0][XLEN-1:0] cwdata;
      logic                       dbg;
      logic [31:0]                irq;
      logic                       chk_rd;
      logic [31:0]                e_rdata;
      logic                       e_valid;
      logic [31:0]                e_xwb;
      logic [31:0]                e_xwdata;
      logic [N_CSR-1:0]           e_csr_wb;
      logic [N_CSR-1:0][XLEN-1:0] e_csr_data;
      logic                       e_halt;
      logic                       e_hevt;
      logic [31:0]                e_irq;
      logic                       e_ievt;
   } row_t;

   logic                       rvvi_i;
   logic                       rst_n_i;
   logic                       cfg_we_i;
   logic [CFG_ADDR_W-1:0]      cfg_addr_i;
   logic [XLEN-1:0]            cfg_wdata_i;
   logic [XLEN-1:0]            cfg_rdata_o;
   logic                       rvfi_valid_i;
   logic [NRET_ORDER_W-1:0]    rvfi_order_i;
   logic [XLEN-1:0]            rvfi_insn_i;
   logic                       rvfi_trap_i;
   logic                       rvfi_intr_i;
   logic [1:0]                 rvfi_mode_i;
   logic [1:0]                 rvfi_ixl_i;
   logic [XLEN-1:0]            rvfi_pc_rdata_i;
   logic [XLEN-1:0]            rvfi_pc_wdata_i;
   logic [4:0]                 rvfi_rd_addr_i;
   logic [XLEN-1:0]            rvfi_rd_wdata_i;
   logic [N_CSR-1:0][XLEN-1:0] csr_wmask_i;
   logic [N_CSR-1:0][XLEN-1:0] csr_wdata_i;
   logic                       debug_req_i;
   logic [31:0]                irq_i;
   logic                       rvvi_valid_o;
   logic [NRET_ORDER_W-1:0]    rvvi_order_o;
   logic [XLEN-1:0]            rvvi_insn_o;
   logic                       rvvi_trap_o;
   logic                       rvvi_intr_o;
   logic [1:0]                 rvvi_mode_o;
   logic [1:0]                 rvvi_ixl_o;
   logic [XLEN-1:0]            rvvi_pc_rdata_o;
   logic [XLEN-1:0]            rvvi_pc_wdata_o;
   logic [31:0]                x_wb_o;
   logic [XLEN-1:0]            x_wdata_o;
   logic [N_CSR-1:0]           csr_wb_o;
   logic [N_CSR-1:0][XLEN-1:0] csr_data_o;
   logic                       halt_o;
   logic                       halt_evt_o;
   logic [31:0]                irq_net_o;
   logic                       irq_evt_o;

   row_t        rows[$];
   row_t        cur;
   logic [2:0]  cur_test;
   logic        dbg_lvl;
   logic [31:0] irq_lvl;
   string       test_name [5] = '{"reset values", "retirement", "CSR writeback",
                                  "halt stretch", "interrupt masking"};
   int          n_checks;
   int          n_errors;
   int          t_checks;
   int          t_errs;
   int          cycles;
   int          cycle_limit;

   // Reference state, advanced once per table row
   logic [N_CSR-1:0]           m_csr_en   = '1;
   logic [HALT_HOLD_W-1:0]     m_hold     = HALT_HOLD_W'(HALT_HOLD_DEFAULT);
   logic [31:0]                m_irq_mask = 32'hFFFF_0888;
   logic [63:0]                m_order    = 64'h0000_0001_0000_0000;
   logic [31:0]                m_xwb      = '0;
   logic [31:0]                m_xwdata   = '0;
   logic [N_CSR-1:0]           m_csr_wb   = '0;
   logic [N_CSR-1:0][XLEN-1:0] m_csr_data = '0;
   logic [31:0]                m_irq_net  = '0;
   logic                       m_h1       = 1'b0;
   logic                       m_h2       = 1'b0;
   logic                       m_seen     = 1'b0;
   int                         m_since    = 0;

   rvvi_trace_top #(
      .HALT_HOLD_DEFAULT (HALT_HOLD_DEFAULT),
      .NRET_ORDER_W      (NRET_ORDER_W)
   ) dut (.*);

   initial begin
      rvvi_i = 1'b0;
      forever #50 rvvi_i = ~rvvi_i;
   end

   ////////////////////////////////////////
   // Table construction
   ////////////////////////////////////////

   // Idle stimulus, debug and irq levels carry over
   task automatic clear_row();
      cur     = '0;
      cur.ixl = 2'b01;
   endtask

   // Random retirement record, CSR masks left for the caller
   task automatic prep_retire(input logic [4:0] rd);
      clear_row();
      m_order       = m_order + 64'(1 + $urandom_range(3));
      cur.valid     = 1'b1;
      cur.order     = m_order;
      cur.insn      = $urandom;
      cur.trap      = 1'($urandom_range(1));
      cur.intr      = 1'($urandom_range(1));
      cur.mode      = 2'($urandom_range(3));
      cur.ixl       = 2'($urandom_range(3));
      cur.pc_r      = $urandom & 32'hFFFF_FFFC;
      cur.pc_w      = cur.pc_r + 32'd4;
      cur.rd        = rd;
      cur.rd_wdata  = $urandom;
      for (int i = 0; i < N_CSR; i++) begin
         cur.cwdata[i] = $urandom;
      end
   endtask

   // Work out what the outputs show after this row's edge, then append it
   task automatic push_row();
      logic        halt_new;
      logic [31:0] irq_new;
      cur.test = cur_test;
      cur.dbg  = dbg_lvl;
      cur.irq  = irq_lvl;
      // Record, x0 gives no writeback
      if (cur.valid) begin
         m_xwb    = (cur.rd == 5'd0) ? 32'd0 : (32'd1 << cur.rd);
         m_xwdata = (cur.rd == 5'd0) ? 32'd0 : cur.rd_wdata;
         for (int i = 0; i < N_CSR; i++) begin
            m_csr_wb[i]   = (cur.wmask[i] != '0) && m_csr_en[i];
            m_csr_data[i] = cur.cwdata[i] & cur.wmask[i];
         end
      end
      cur.e_valid    = cur.valid;
      cur.e_xwb      = m_xwb;
      cur.e_xwdata   = m_xwdata;
      cur.e_csr_wb   = m_csr_wb;
      cur.e_csr_data = m_csr_data;
      // Halt high on a request, then for hold more edges
      if (cur.dbg) begin
         m_since = 0;
         m_seen  = 1'b1;
      end else if (m_seen) begin
         m_since++;
      end
      halt_new   = cur.dbg || (m_seen && m_since <= int'(m_hold));
      cur.e_halt = halt_new;
      cur.e_hevt = (m_h1 != m_h2);
      m_h2       = m_h1;
      m_h1       = halt_new;
      // Masked lines and change pulse
      irq_new    = cur.irq & m_irq_mask;
      cur.e_irq  = irq_new;
      cur.e_ievt = (irq_new != m_irq_net);
      m_irq_net  = irq_new;
      // Read-back sees the state before this row's write
      case (cur.addr)
         CFG_CSR_EN:    cur.e_rdata = 32'(m_csr_en);
         CFG_HALT_HOLD: cur.e_rdata = 32'(m_hold);
         CFG_IRQ_MASK:  cur.e_rdata = m_irq_mask;
         default:       cur.e_rdata = '0;
      endcase
      if (cur.we) begin
         case (cur.addr)
            CFG_CSR_EN:    m_csr_en   = cur.wdata[N_CSR-1:0];
            CFG_HALT_HOLD: m_hold     = cur.wdata[HALT_HOLD_W-1:0];
            CFG_IRQ_MASK:  m_irq_mask = cur.wdata;
            default: ;
         endcase
      end
      rows.push_back(cur);
   endtask

   task automatic add_idle(input int n);
      repeat (n) begin
         clear_row();
         push_row();
      end
   endtask

   task automatic add_cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [31:0] data);
      clear_row();
      cur.we    = 1'b1;
      cur.addr  = addr;
      cur.wdata = data;
      push_row();
   endtask

   task automatic add_cfg_read(input logic [CFG_ADDR_W-1:0] addr);
      clear_row();
      cur.addr   = addr;
      cur.chk_rd = 1'b1;
      push_row();
   endtask

   task automatic build_table();
      cur_test = 3'd0;
      add_cfg_read(CFG_CSR_EN);
      add_cfg_read(CFG_HALT_HOLD);
      add_cfg_read(CFG_IRQ_MASK);
      // Retirement, x0 included
      cur_test = 3'd1;
      prep_retire(5'd5);
      push_row();
      prep_retire(5'd0);
      push_row();
      prep_retire(5'd31);
      push_row();
      add_idle(1);
      // Partial CSR masks, then mip compare disabled
      cur_test = 3'd2;
      prep_retire(5'd10);
      cur.wmask[CSR_MSTATUS] = $urandom & 32'h0000_FF0F;
      cur.wmask[CSR_MEPC]    = 32'hFFFF_FFFC;
      cur.wmask[CSR_MIP]     = 32'h0000_0888;
      push_row();
      prep_retire(5'd11);
      push_row();
      add_cfg_write(CFG_CSR_EN, 32'h0000_FFFF & ~(32'd1 << CSR_MIP));
      add_cfg_read(CFG_CSR_EN);
      prep_retire(5'd12);
      cur.wmask[CSR_MIP]  = 32'h0000_0080;
      cur.wmask[CSR_MEPC] = 32'h0000_00F0;
      push_row();
      add_idle(1);
      // Default hold, then hold of zero
      cur_test = 3'd3;
      dbg_lvl  = 1'b1;
      add_idle(3);
      dbg_lvl  = 1'b0;
      add_idle(8);
      add_cfg_write(CFG_HALT_HOLD, 32'd0);
      add_cfg_read(CFG_HALT_HOLD);
      dbg_lvl  = 1'b1;
      add_idle(3);
      dbg_lvl  = 1'b0;
      add_idle(4);
      // Enabled line 3, masked line 5, then line 5 enabled
      cur_test = 3'd4;
      irq_lvl  = 32'd1 << 3;
      add_idle(2);
      irq_lvl  = '0;
      add_idle(2);
      irq_lvl  = 32'd1 << 5;
      add_idle(2);
      irq_lvl  = '0;
      add_idle(2);
      add_cfg_write(CFG_IRQ_MASK, 32'hFFFF_0888 | (32'd1 << 5));
      add_cfg_read(CFG_IRQ_MASK);
      irq_lvl  = 32'd1 << 5;
      add_idle(2);
      irq_lvl  = '0;
      add_idle(2);
   endtask

   ////////////////////////////////////////
   // Drive and check
   ////////////////////////////////////////
   task automatic drive_row(input row_t r);
      cfg_we_i        = r.we;
      cfg_addr_i      = r.addr;
      cfg_wdata_i     = r.wdata;
      rvfi_valid_i    = r.valid;
      rvfi_order_i    = r.order;
      rvfi_insn_i     = r.insn;
      rvfi_trap_i     = r.trap;
      rvfi_intr_i     = r.intr;
      rvfi_mode_i     = r.mode;
      rvfi_ixl_i      = r.ixl;
      rvfi_pc_rdata_i = r.pc_r;
      rvfi_pc_wdata_i = r.pc_w;
      rvfi_rd_addr_i  = r.rd;
      rvfi_rd_wdata_i = r.rd_wdata;
      csr_wmask_i     = r.wmask;
      csr_wdata_i     = r.cwdata;
      debug_req_i     = r.dbg;
      irq_i           = r.irq;
   endtask

   task automatic check_val(input string name, input logic [63:0] act, input logic [63:0] exp);
      n_checks++;
      t_checks++;
      assert (act === exp) else begin
         $display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, act, exp);
         n_errors++;
         t_errs++;
      end
   endtask

   task automatic check_row(input row_t r);
      check_val("rvvi_valid_o", 64'(rvvi_valid_o), 64'(r.e_valid));
      check_val("x_wb_o", 64'(x_wb_o), 64'(r.e_xwb));
      check_val("csr_wb_o", 64'(csr_wb_o), 64'(r.e_csr_wb));
      check_val("halt_o", 64'(halt_o), 64'(r.e_halt));
      check_val("halt_evt_o", 64'(halt_evt_o), 64'(r.e_hevt));
      check_val("irq_net_o", 64'(irq_net_o), 64'(r.e_irq));
      check_val("irq_evt_o", 64'(irq_evt_o), 64'(r.e_ievt));
      if (r.chk_rd) begin
         check_val("cfg_rdata_o", 64'(cfg_rdata_o), 64'(r.e_rdata));
      end
      // Payload has no reset, so only after a retirement
      if (r.valid) begin
         check_val("rvvi_order_o", rvvi_order_o, r.order);
         check_val("rvvi_insn_o", 64'(rvvi_insn_o), 64'(r.insn));
         check_val("rvvi_trap_o", 64'(rvvi_trap_o), 64'(r.trap));
         check_val("rvvi_intr_o", 64'(rvvi_intr_o), 64'(r.intr));
         check_val("rvvi_mode_o", 64'(rvvi_mode_o), 64'(r.mode));
         check_val("rvvi_ixl_o", 64'(rvvi_ixl_o), 64'(r.ixl));
         check_val("rvvi_pc_rdata_o", 64'(rvvi_pc_rdata_o), 64'(r.pc_r));
         check_val("rvvi_pc_wdata_o", 64'(rvvi_pc_wdata_o), 64'(r.pc_w));
         check_val("x_wdata_o", 64'(x_wdata_o), 64'(r.e_xwdata));
         for (int i = 0; i < N_CSR; i++) begin
            check_val($sformatf("csr_data_o[%03h]", csr_addr_tab[i]),
                      64'(csr_data_o[i]), 64'(r.e_csr_data[i]));
         end
      end
   endtask

   task automatic report_test(input logic [2:0] t);
      $display("Test %0d %s: %0d checks, %0d errors, %s", t, test_name[t], t_checks, t_errs,
               (t_errs == 0) ? "ok" : "FAILED");
      t_checks = 0;
      t_errs   = 0;
   endtask

   // Run limit from the table length
   initial begin
      cycles = 0;
      wait (cycle_limit != 0);
      while (cycles < cycle_limit) begin
         @(posedge rvvi_i);
         cycles++;
      end
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
   end

   initial begin
      void'($urandom(32'h8fb9_fe34));
      n_checks = 0;
      n_errors = 0;
      t_checks = 0;
      t_errs   = 0;
      dbg_lvl  = 1'b0;
      irq_lvl  = '0;
      rst_n_i  = 1'b0;
      clear_row();
      drive_row(cur);
      build_table();
      cycle_limit = 2 * rows.size() + 50;
      // Reset for two cycles
      repeat (2) @(posedge rvvi_i);
      #10;
      rst_n_i = 1'b1;
      drive_row(rows[0]);
      // Outputs checked 5 ns after the edge, next row driven at 10 ns
      for (int i = 0; i < rows.size(); i++) begin
         @(posedge rvvi_i);
         #5;
         check_row(rows[i]);
         #5;
         if (i + 1 < rows.size()) begin
            drive_row(rows[i + 1]);
         end
         if (i + 1 == rows.size() || rows[i + 1].test != rows[i].test) begin
            report_test(rows[i].test);
         end
      end
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* rvvi_trace_top.f */
src/rvvi_pkg.sv
src/rvvi_cfg_regs.sv
src/rvvi_retire_capture.sv
src/rvvi_csr_trace.sv
src/rvvi_halt_stretch.sv
src/rvvi_irq_tracker.sv
src/rvvi_trace_top.sv
verification/rvvi_trace_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the trace adapter testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f rvvi_trace_top.f --top-module rvvi_trace_tb \
   --Mdir obj_dir -o rvvi_trace_sim > sim.log 2>&1 \
   && ./obj_dir/rvvi_trace_sim >> sim.log 2>&1 \
   || echo "Build or simulation ended with an error" >> sim.log

grep -qx "Verification passed" sim.log \
   && echo "PASS: see sim.log" \
   || { echo "FAIL: see sim.log"; exit 1; }
